//--- Makefile
# Verilator build and run of the DNC write weighting testbench

TOP = dnc_write_weighting_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# Pass only when the testbench prints its pass message
test:
	verilator --binary --assert --top-module $(TOP) -f sources.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- bench/dnc_write_weighting_checker.sv
/*
  Handshake and timing assertions for the DNC write weighting unit
*/
`include "dnc_macros.svh"

module dnc_write_weighting_checker (
  input logic CLK,
  input logic RST,
  input logic START,
  input logic READY,
  input logic A_OUT_ENABLE,
  input logic A_IN_ENABLE,
  input logic C_IN_ENABLE,
  input logic W_OUT_ENABLE
);

  logic accept;

  // Element taken this cycle
  assign accept = A_OUT_ENABLE && A_IN_ENABLE && C_IN_ENABLE;

  //////////////////////////////
  // Timing
  //////////////////////////////

  // Fixed latency with no output back-pressure
  assert property (@(posedge CLK) disable iff (RST)
    accept |-> ##`DNC_PIPE_DEPTH W_OUT_ENABLE)
    else $error("W_OUT_ENABLE missing %0d cycles after acceptance", `DNC_PIPE_DEPTH);

  // READY rides on the last output for one cycle only
  assert property (@(posedge CLK) disable iff (RST) READY |-> W_OUT_ENABLE ##1 !READY)
    else $error("READY not a one-cycle pulse with W_OUT_ENABLE");

  //////////////////////////////
  // Framing
  //////////////////////////////

  // START mid-job leaves the request alone
  assert property (@(posedge CLK) disable iff (RST)
    (START && A_OUT_ENABLE && !(A_IN_ENABLE && C_IN_ENABLE)) |=> A_OUT_ENABLE)
    else $error("START during a running job changed A_OUT_ENABLE");

endmodule

bind dnc_write_weighting dnc_write_weighting_checker u_checker (
  .CLK          (CLK),
  .RST          (RST),
  .START        (START),
  .READY        (READY),
  .A_OUT_ENABLE (A_OUT_ENABLE),
  .A_IN_ENABLE  (A_IN_ENABLE),
  .C_IN_ENABLE  (C_IN_ENABLE),
  .W_OUT_ENABLE (W_OUT_ENABLE)
);

//--- bench/dnc_write_weighting_tb.sv
/*
  Testbench for the DNC write weighting unit
  Random jobs, gate clamping, extremes, stalls and ignored STARTs
*/
`include "dnc_macros.svh"

module dnc_write_weighting_tb;

  localparam int NUM_JOBS     = 14;
  localparam int GATE_ONE     = 1 << `DNC_FRAC_BITS;
  localparam int WORD_MAX     = (1 << (`DNC_DATA_SIZE - 1)) - 1;
  localparam int WORD_MIN     = -WORD_MAX - 1;
  // Job kinds
  localparam int KIND_PLAIN   = 0;
  localparam int KIND_EXTREME = 1;
  localparam int KIND_STALL   = 2;
  localparam int KIND_BUSY    = 3;

  logic                CLK;
  logic                RST;
  logic                START;
  logic                READY;
  dnc_num_pkg::index_t SIZE_N_IN;
  dnc_num_pkg::word_t  GA_IN;
  dnc_num_pkg::word_t  GW_IN;
  dnc_num_pkg::word_t  A_IN;
  dnc_num_pkg::word_t  C_IN;
  logic                A_IN_ENABLE;
  logic                C_IN_ENABLE;
  logic                A_OUT_ENABLE;
  logic                C_OUT_ENABLE;
  dnc_num_pkg::word_t  W_OUT;
  logic                W_OUT_ENABLE;

  int seed        = 14031;
  int error_count = 0;
  int out_count   = 0;
  int ready_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;
  int sample_idx  = 0;
  int job_accepts = 0;

  // Job table filled once at start
  int                 job_n    [NUM_JOBS];
  int                 job_kind [NUM_JOBS];
  dnc_num_pkg::word_t job_ga   [NUM_JOBS];
  dnc_num_pkg::word_t job_gw   [NUM_JOBS];

  // Gates of the running job
  int                 cur_n;
  dnc_num_pkg::word_t cur_ga;
  dnc_num_pkg::word_t cur_gw;

  // Model of the job framing seen at the ports
  logic               fsm_idle;
  logic               req_expected;

  // Expected value, due sample and last flag per accepted element
  dnc_num_pkg::word_t exp_q  [$];
  int                 due_q  [$];
  logic               last_q [$];

  dnc_write_weighting u_dnc_write_weighting (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (READY),
    .SIZE_N_IN    (SIZE_N_IN),
    .GA_IN        (GA_IN),
    .GW_IN        (GW_IN),
    .A_IN         (A_IN),
    .C_IN         (C_IN),
    .A_IN_ENABLE  (A_IN_ENABLE),
    .C_IN_ENABLE  (C_IN_ENABLE),
    .A_OUT_ENABLE (A_OUT_ENABLE),
    .C_OUT_ENABLE (C_OUT_ENABLE),
    .W_OUT        (W_OUT),
    .W_OUT_ENABLE (W_OUT_ENABLE)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int rand_below(input int span);
    logic [31:0] r;
    r = $random(seed);
    return int'(r[15:0]) % span;
  endfunction

  // Gate range 0 to 1.0
  function automatic int limit_gate(input dnc_num_pkg::word_t raw);
    if (raw < 0)
      return 0;
    if (int'(raw) > GATE_ONE)
      return GATE_ONE;
    return int'(raw);
  endfunction

  // w = gw*(ga*a + (1-ga)*c) with each product floored by the shift
  function automatic dnc_num_pkg::word_t ref_weight(input dnc_num_pkg::word_t a,
                                                    input dnc_num_pkg::word_t c,
                                                    input dnc_num_pkg::word_t ga_raw,
                                                    input dnc_num_pkg::word_t gw_raw);
    int ga;
    int gw;
    int mix;
    int w;
    ga  = limit_gate(ga_raw);
    gw  = limit_gate(gw_raw);
    mix = ((int'(a) * ga) >>> `DNC_FRAC_BITS) +
          ((int'(c) * (GATE_ONE - ga)) >>> `DNC_FRAC_BITS);
    w   = (mix * gw) >>> `DNC_FRAC_BITS;
    if (w > WORD_MAX)
      w = WORD_MAX;
    else if (w < WORD_MIN)
      w = WORD_MIN;
    return dnc_num_pkg::word_t'(w);
  endfunction

  task automatic check_value(input string name, input int got, input int expected);
    if (got !== expected) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
      error_count++;
    end
  endtask

  task automatic report_counts();
    $display("Outputs checked: %0d, READY pulses: %0d, errors: %0d",
             out_count, ready_count, error_count);
  endtask

  //////////////////////////////
  // Comparing process
  //////////////////////////////

  // Samples at the rising edge after inputs settled on the falling one
  always @(posedge CLK) begin
    if (!RST) begin
      // Both requests follow the job framing
      check_value("A_OUT_ENABLE", int'(A_OUT_ENABLE), int'(req_expected));
      check_value("C_OUT_ENABLE", int'(C_OUT_ENABLE), int'(req_expected));
      if (W_OUT_ENABLE) begin
        if (exp_q.size() == 0) begin
          $display("Output appeared with no accepted element pending");
          error_count++;
        end else begin
          check_value("W_OUT", int'(W_OUT), int'(exp_q.pop_front()));
          check_value("W_OUT_ENABLE cycle", sample_idx, due_q.pop_front());
          check_value("READY", int'(READY), int'(last_q.pop_front()));
        end
        out_count++;
      end else if (READY) begin
        $display("READY pulsed without an output");
        error_count++;
      end
      if (READY)
        ready_count++;
      // Acceptance seen at the ports
      if (A_OUT_ENABLE && A_IN_ENABLE && C_IN_ENABLE) begin
        exp_q.push_back(ref_weight(A_IN, C_IN, cur_ga, cur_gw));
        due_q.push_back(sample_idx + `DNC_PIPE_DEPTH);
        last_q.push_back(job_accepts == cur_n - 1);
        if (job_accepts == cur_n - 1) begin
          job_accepts  = 0;
          req_expected = 1'b0;
        end else begin
          job_accepts++;
        end
      end
      // START counts only when idle with a nonzero size
      if (fsm_idle && START && SIZE_N_IN != '0) begin
        fsm_idle     = 1'b0;
        req_expected = 1'b1;
      end
      // Back to idle after the final output
      if (READY)
        fsm_idle = 1'b1;
    end
    sample_idx++;
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic plan_jobs();
    int total;
    total = 0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      job_n[j]    = 1 + rand_below(20);
      job_ga[j]   = dnc_num_pkg::word_t'(rand_below(GATE_ONE + 1));
      job_gw[j]   = dnc_num_pkg::word_t'(rand_below(GATE_ONE + 1));
      job_kind[j] = (j < 10) ? KIND_PLAIN : (j < 12) ? KIND_STALL : KIND_BUSY;
    end
    job_n[0]    = 1;
    // ga above 1.0 and below 0
    job_ga[6]   = 16'sd300;
    job_ga[7]   = -16'sd5;
    // Word limits with gw above 1.0
    // w follows a in job 8 and c in job 9
    job_kind[8] = KIND_EXTREME;
    job_ga[8]   = 16'sd256;
    job_gw[8]   = 16'sh7fff;
    job_kind[9] = KIND_EXTREME;
    job_ga[9]   = 16'sd0;
    job_gw[9]   = 16'sh4000;
    // Stall allowance plus pipeline per job
    for (int j = 0; j < NUM_JOBS; j++)
      total += 2 * job_n[j] + 8;
    cycle_limit = 2 * total + 200;
  endtask

  task automatic drive_element(input int kind);
    logic [31:0] r;
    r           = $random(seed);
    A_IN        = r[15:0];
    C_IN        = r[31:16];
    A_IN_ENABLE = 1'b1;
    C_IN_ENABLE = 1'b1;
    case (kind)
      KIND_EXTREME: begin
        A_IN = r[0] ? 16'sh7fff : 16'sh8000;
        C_IN = r[1] ? 16'sh7fff : 16'sh8000;
      end
      KIND_STALL: begin
        A_IN_ENABLE = rand_below(4) != 0;
        C_IN_ENABLE = rand_below(4) != 0;
      end
      KIND_BUSY: begin
        // Competing job offered mid-stream
        START       = rand_below(3) == 0;
        SIZE_N_IN   = dnc_num_pkg::index_t'(rand_below(20));
        GA_IN       = r[31:16];
        GW_IN       = r[15:0];
        // Some stalls so START also meets a waiting request
        A_IN_ENABLE = rand_below(4) != 0;
      end
      default: ;
    endcase
  endtask

  task automatic run_job(input int j);
    @(negedge CLK);
    cur_n     = job_n[j];
    cur_ga    = job_ga[j];
    cur_gw    = job_gw[j];
    START     = 1'b1;
    SIZE_N_IN = dnc_num_pkg::index_t'(job_n[j]);
    GA_IN     = job_ga[j];
    GW_IN     = job_gw[j];
    @(negedge CLK);
    START = 1'b0;
    // Request drops after element N
    while (A_OUT_ENABLE) begin
      drive_element(job_kind[j]);
      @(negedge CLK);
    end
    A_IN_ENABLE = 1'b0;
    C_IN_ENABLE = 1'b0;
    START       = 1'b0;
    if (job_kind[j] == KIND_BUSY) begin
      // START while draining
      START     = 1'b1;
      SIZE_N_IN = dnc_num_pkg::index_t'(5);
      @(negedge CLK);
      START = 1'b0;
    end
    do
      @(posedge CLK);
    while (!READY);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    RST          = 1'b1;
    START        = 1'b0;
    SIZE_N_IN    = '0;
    GA_IN        = '0;
    GW_IN        = '0;
    A_IN         = '0;
    C_IN         = '0;
    A_IN_ENABLE  = 1'b0;
    C_IN_ENABLE  = 1'b0;
    cur_n        = 0;
    cur_ga       = '0;
    cur_gw       = '0;
    fsm_idle     = 1'b1;
    req_expected = 1'b0;
    plan_jobs();
    repeat (10) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    // Idle outputs after reset
    check_value("READY", int'(READY), 0);
    check_value("W_OUT_ENABLE", int'(W_OUT_ENABLE), 0);
    check_value("A_OUT_ENABLE", int'(A_OUT_ENABLE), 0);
    check_value("W_OUT", int'(W_OUT), 0);
    // Zero-length job never starts
    START     = 1'b1;
    SIZE_N_IN = '0;
    @(negedge CLK);
    START = 1'b0;
    repeat (4) @(negedge CLK);
    check_value("A_OUT_ENABLE", int'(A_OUT_ENABLE), 0);
    check_value("READY count", ready_count, 0);
    for (int j = 0; j < NUM_JOBS; j++)
      run_job(j);
    repeat (5) @(negedge CLK);
    check_value("READY count", ready_count, NUM_JOBS);
    check_value("pending outputs", exp_q.size(), 0);
    report_counts();
    if (error_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // Run limit from the job table
  initial begin
    do begin
      @(posedge CLK);
      cycle_count++;
    end while (cycle_count < cycle_limit);
    $display("Timeout after %0d cycles, the jobs did not complete", cycle_count);
    report_counts();
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- source/dnc_ctrl_pkg.sv
/*
  Control types of the write weighting unit
  Job state of the decode stage
*/
package dnc_ctrl_pkg;

  //////////////////////////////
  // Job state
  //////////////////////////////

  // IDLE waits for START
  // STREAM requests and accepts elements
  // DRAIN waits for the last result to leave
  typedef enum logic [1:0] {
    IDLE,
    STREAM,
    DRAIN
  } job_state_t;

endpackage

//--- source/dnc_macros.svh
/*
  Write weighting sizes
  Word format and pipeline constants shared by the design
*/
`ifndef DNC_MACROS_SVH
`define DNC_MACROS_SVH

// Q8.8 signed data word
`define DNC_DATA_SIZE 16
`define DNC_FRAC_BITS 8

// Row count width, N up to 255
`define DNC_INDEX_SIZE 8

// Acceptance to W_OUT_ENABLE
`define DNC_PIPE_DEPTH 3

`endif

//--- source/dnc_num_pkg.sv
/*
  Numeric types of the write weighting datapath
  Fixed-point words, clamped gates, products and row counters
*/
`include "dnc_macros.svh"

package dnc_num_pkg;

  //////////////////////////////
  // Data words
  //////////////////////////////

  // Signed Q8.8 element or result
  typedef logic signed [`DNC_DATA_SIZE-1:0] word_t;

  // Gate after clamping, 256 is 1.0
  typedef logic [`DNC_FRAC_BITS:0] gate_t;

  // Full product before the shift
  typedef logic signed [2*`DNC_DATA_SIZE-1:0] product_t;

  //////////////////////////////
  // Counters
  //////////////////////////////

  typedef logic [`DNC_INDEX_SIZE-1:0] index_t;

endpackage

//--- source/dnc_write_weighting.sv
/*
  DNC write weighting, w = gw*(ga*a + (1-ga)*c)
  Decode, execute and result stages behind plain ports
*/
module dnc_write_weighting (
  input  logic                CLK,
  input  logic                RST,

  // Job control
  input  logic                START,
  output logic                READY,
  input  dnc_num_pkg::index_t SIZE_N_IN,
  input  dnc_num_pkg::word_t  GA_IN,
  input  dnc_num_pkg::word_t  GW_IN,

  // Element stream
  input  dnc_num_pkg::word_t  A_IN,
  input  dnc_num_pkg::word_t  C_IN,
  input  logic                A_IN_ENABLE,
  input  logic                C_IN_ENABLE,
  output logic                A_OUT_ENABLE,
  output logic                C_OUT_ENABLE,

  // Result stream
  output dnc_num_pkg::word_t  W_OUT,
  output logic                W_OUT_ENABLE
);

  logic               request;
  dnc_num_pkg::gate_t gw;
  logic               mix_valid;
  logic               mix_last;
  dnc_num_pkg::word_t mix;

  gate_op_if u_gate_op ();

  //////////////////////////////
  // Stages
  //////////////////////////////

  // Both streams are requested together
  assign A_OUT_ENABLE = request;
  assign C_OUT_ENABLE = request;

  weighting_decode u_decode (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .size_n      (SIZE_N_IN),
    .ga_raw      (GA_IN),
    .gw_raw      (GW_IN),
    .a_in        (A_IN),
    .c_in        (C_IN),
    .a_in_enable (A_IN_ENABLE),
    .c_in_enable (C_IN_ENABLE),
    .done        (READY),
    .request     (request),
    .gw          (gw),
    .op          (u_gate_op)
  );

  weighting_execute u_execute (
    .CLK       (CLK),
    .RST       (RST),
    .op        (u_gate_op),
    .mix_valid (mix_valid),
    .mix_last  (mix_last),
    .mix       (mix)
  );

  // READY doubles as done for the decode FSM
  weighting_result u_result (
    .CLK          (CLK),
    .RST          (RST),
    .mix_valid    (mix_valid),
    .mix_last     (mix_last),
    .mix          (mix),
    .gw           (gw),
    .w_out        (W_OUT),
    .w_out_enable (W_OUT_ENABLE),
    .ready        (READY)
  );

endmodule

//--- source/gate_op_if.sv
/*
  Gated element link from decode to execute
*/
interface gate_op_if;

  // One element per high valid
  logic                valid;
  // Marks element N of the job
  logic                last;

  // Operands as accepted
  dnc_num_pkg::word_t  a;
  dnc_num_pkg::word_t  c;

  // Clamped gate and its complement, held for the job
  dnc_num_pkg::gate_t  ga;
  dnc_num_pkg::gate_t  ga_comp;

  modport decode (output valid, last, a, c, ga, ga_comp);

  modport execute (input valid, last, a, c, ga, ga_comp);

endinterface

//--- source/weighting_decode.sv
/*
  Write weighting decode stage
  Job framing, gate clamping, element requests and acceptance
*/
`include "dnc_macros.svh"

module weighting_decode (
  input  logic                CLK,
  input  logic                RST,
  input  logic                START,
  input  dnc_num_pkg::index_t size_n,
  input  dnc_num_pkg::word_t  ga_raw,
  input  dnc_num_pkg::word_t  gw_raw,
  input  dnc_num_pkg::word_t  a_in,
  input  dnc_num_pkg::word_t  c_in,
  input  logic                a_in_enable,
  input  logic                c_in_enable,
  input  logic                done,
  output logic                request,
  output dnc_num_pkg::gate_t  gw,
  gate_op_if.decode           op
);

  // Gate value of 1.0
  localparam dnc_num_pkg::gate_t GATE_ONE = dnc_num_pkg::gate_t'(1 << `DNC_FRAC_BITS);

  // Negative to 0, above 1.0 to 1.0
  function automatic dnc_num_pkg::gate_t clamp_gate(input dnc_num_pkg::word_t raw);
    if (raw < 0)
      return '0;
    else if (raw > dnc_num_pkg::word_t'(GATE_ONE))
      return GATE_ONE;
    else
      return dnc_num_pkg::gate_t'(raw);
  endfunction

  dnc_ctrl_pkg::job_state_t state;
  dnc_num_pkg::index_t      n_latched;
  dnc_num_pkg::index_t      accepted;
  dnc_num_pkg::gate_t       ga_clamped;
  logic                     job_start;
  logic                     accept;
  logic                     at_last;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Zero-length jobs never leave IDLE
  assign job_start  = (state == dnc_ctrl_pkg::IDLE) && START && (size_n != '0);
  assign ga_clamped = clamp_gate(ga_raw);

  // Ask for elements until N have been taken
  assign request = (state == dnc_ctrl_pkg::STREAM) && (accepted < n_latched);
  assign accept  = request && a_in_enable && c_in_enable;
  assign at_last = accepted == (n_latched - dnc_num_pkg::index_t'(1));

  //////////////////////////////
  // Job FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= dnc_ctrl_pkg::IDLE;
      accepted <= '0;
      op.valid <= 1'b0;
      op.last  <= 1'b0;
    end else begin
      // Registered acceptance, first of DNC_PIPE_DEPTH stages
      op.valid <= accept;
      op.last  <= accept && at_last;
      case (state)
        dnc_ctrl_pkg::IDLE: begin
          if (job_start) begin
            state    <= dnc_ctrl_pkg::STREAM;
            accepted <= '0;
          end
        end
        dnc_ctrl_pkg::STREAM: begin
          if (accept) begin
            accepted <= accepted + dnc_num_pkg::index_t'(1);
            // Stop requesting after element N
            if (at_last)
              state <= dnc_ctrl_pkg::DRAIN;
          end
        end
        dnc_ctrl_pkg::DRAIN: begin
          // Result stage signals the final output
          if (done)
            state <= dnc_ctrl_pkg::IDLE;
        end
        default: state <= dnc_ctrl_pkg::IDLE;
      endcase
    end
  end

  // Job parameters and operands
  always_ff @(posedge CLK) begin
    if (job_start) begin
      n_latched  <= size_n;
      op.ga      <= ga_clamped;
      op.ga_comp <= GATE_ONE - ga_clamped;
      gw         <= clamp_gate(gw_raw);
    end
    if (accept) begin
      op.a <= a_in;
      op.c <= c_in;
    end
  end

endmodule

//--- source/weighting_execute.sv
/*
  Write weighting execute stage
  Gated mix ga*a + (1-ga)*c, one element per cycle
*/
`include "dnc_macros.svh"

module weighting_execute (
  input  logic               CLK,
  input  logic               RST,
  gate_op_if.execute         op,
  output logic               mix_valid,
  output logic               mix_last,
  output dnc_num_pkg::word_t mix
);

  dnc_num_pkg::product_t prod_a;
  dnc_num_pkg::product_t prod_c;
  dnc_num_pkg::product_t sum;

  //////////////////////////////
  // Products
  //////////////////////////////

  // Gates are zero-extended, operands sign-extended
  assign prod_a = dnc_num_pkg::product_t'(op.a) * dnc_num_pkg::product_t'(op.ga);
  assign prod_c = dnc_num_pkg::product_t'(op.c) * dnc_num_pkg::product_t'(op.ga_comp);

  // Each term truncated on its own
  // Gates sum to 1.0, so the floored sum stays in word range
  assign sum = (prod_a >>> `DNC_FRAC_BITS) + (prod_c >>> `DNC_FRAC_BITS);

  //////////////////////////////
  // Stage register
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      mix_valid <= 1'b0;
      mix_last  <= 1'b0;
    end else begin
      mix_valid <= op.valid;
      mix_last  <= op.valid && op.last;
    end
  end

  // Mix only moves with a valid element
  always_ff @(posedge CLK) begin
    if (op.valid)
      mix <= dnc_num_pkg::word_t'(sum);
  end

endmodule

//--- source/weighting_result.sv
/*
  Write weighting result stage
  Write-gate scaling, saturation and job completion
*/
`include "dnc_macros.svh"

module weighting_result (
  input  logic               CLK,
  input  logic               RST,
  input  logic               mix_valid,
  input  logic               mix_last,
  input  dnc_num_pkg::word_t mix,
  input  dnc_num_pkg::gate_t gw,
  output dnc_num_pkg::word_t w_out,
  output logic               w_out_enable,
  output logic               ready
);

  // Word limits in product width
  localparam dnc_num_pkg::product_t SAT_MAX =
    (dnc_num_pkg::product_t'(1) <<< (`DNC_DATA_SIZE - 1)) - 1;
  localparam dnc_num_pkg::product_t SAT_MIN = -SAT_MAX - 1;

  dnc_num_pkg::product_t scaled;
  dnc_num_pkg::word_t    sat;

  //////////////////////////////
  // Scaling
  //////////////////////////////

  // gw * mix back in Q8.8
  assign scaled = (dnc_num_pkg::product_t'(mix) * dnc_num_pkg::product_t'(gw))
                  >>> `DNC_FRAC_BITS;

  // Clip to the signed word range
  always_comb begin
    if (scaled > SAT_MAX)
      sat = dnc_num_pkg::word_t'(SAT_MAX);
    else if (scaled < SAT_MIN)
      sat = dnc_num_pkg::word_t'(SAT_MIN);
    else
      sat = dnc_num_pkg::word_t'(scaled);
  end

  //////////////////////////////
  // Output registers
  //////////////////////////////

  // Last stage of DNC_PIPE_DEPTH
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      w_out        <= '0;
      w_out_enable <= 1'b0;
      ready        <= 1'b0;
    end else begin
      w_out_enable <= mix_valid;
      // Pulse with the output of element N
      ready        <= mix_valid && mix_last;
      if (mix_valid)
        w_out <= sat;
    end
  end

endmodule

//--- sources.f
+incdir+source
source/dnc_num_pkg.sv
source/dnc_ctrl_pkg.sv
source/gate_op_if.sv
source/weighting_decode.sv
source/weighting_execute.sv
source/weighting_result.sv
source/dnc_write_weighting.sv
bench/dnc_write_weighting_checker.sv
bench/dnc_write_weighting_tb.sv
